// ==== bench/cart_mem_properties.sv ====
`default_nettype none

module cart_mem_properties (
  input wire                       CLK2,
  input wire                       rst_n,
  input wire                       rom_ble_n,
  input wire                       rom_bhe_n,
  input wire                       rom_we_n,
  input wire                       mcu_rdy,
  input wire cart_pkg::arb_state_t state
);

  import cart_pkg::*;

  int assert_fails = 0; // Read by the testbench at the end

  // Exactly one byte lane enabled
  lane_select: assert property (@(posedge CLK2) disable iff (!rst_n) rom_ble_n != rom_bhe_n)
    else begin assert_fails++; $error("lane enables not complementary"); end

  // Writes only while the MCU waits
  write_owner: assert property (@(posedge CLK2) disable iff (!rst_n) !rom_we_n |-> !mcu_rdy)
    else begin assert_fails++; $error("rom_we_n low while mcu_rdy high"); end

  ready_after_reset: assert property (@(posedge CLK2) $rose(rst_n) |-> mcu_rdy)
    else begin assert_fails++; $error("mcu_rdy low after reset release"); end

  legal_state: assert property (@(posedge CLK2) disable iff (!rst_n)
    state inside {IDLE, MCU_RD_ADDR, MCU_RD_END, MCU_WR_ADDR, MCU_WR_END})
    else begin assert_fails++; $error("arbiter state outside the enum"); end

endmodule

bind cart_mem_top cart_mem_properties u_props (
  .CLK2      (CLK2),
  .rst_n     (rst_n),
  .rom_ble_n (rom_ble_n),
  .rom_bhe_n (rom_bhe_n),
  .rom_we_n  (rom_we_n),
  .mcu_rdy   (mcu_rdy),
  .state     (u_arbiter.state)
);

`default_nettype wire

// ==== bench/cart_mem_tb.sv ====
`default_nettype none

module cart_mem_tb;

  import cart_pkg::*;

  localparam int num_ops   = 300;
  localparam int mem_bytes = 2048; // Byte window decoded by the PSRAM model
  localparam int rdy_limit = 2000;

  logic           CLK2, rst_n;
  logic           snes_cpu_clk, snes_romsel_n, snes_read_n, snes_write_n;
  rom_addr_t      snes_addr, mcu_addr;
  cart_byte_t     snes_rdata, mcu_wdata, mcu_rdata;
  logic           snes_databus_oe_n, snes_databus_dir;
  logic           mcu_rrq, mcu_wrq, mcu_rdy;
  rom_word_addr_t rom_addr;
  logic           rom_we_n, rom_ble_n, rom_bhe_n;
  rom_word_t      rom_wdata, rom_rdata;

  cart_byte_t ref_mem [0:mem_bytes-1]; // Expected memory contents
  int         errors;
  int         checks;
  int         clk_mode;                // Console clock 0 low, 1 high, 2 random

  cart_mem_top #(.dead_timeout(200)) DUT (.*);

  psram_model u_psram (
    .CLK2(CLK2), .addr(rom_addr), .we_n(rom_we_n), .ble_n(rom_ble_n),
    .bhe_n(rom_bhe_n), .wdata(rom_wdata), .rdata(rom_rdata)
  );

  initial begin
    CLK2 = 1'b0;
    forever #10 CLK2 = ~CLK2;
  end

  //////////////////////////////
  // Console clock driver
  initial begin : console_clock
    int hold;
    int mode;
    hold = 0;
    forever begin
      @(posedge CLK2);
      mode = clk_mode; // Mode as set before this edge
      #2;
      if (mode == 0) snes_cpu_clk = 1'b0;
      else if (mode == 1) snes_cpu_clk = 1'b1;
      else if (hold > 0) hold--;
      else begin
        snes_cpu_clk  = ~snes_cpu_clk;
        snes_romsel_n = $urandom_range(0, 1);
        hold          = $urandom_range(3, 8);
        if (!snes_cpu_clk && $urandom_range(0, 24) == 0) hold = 260; // Long stop, console dies
      end
    end
  end

  initial begin : watchdog
    #((40 + num_ops) * 600 * 20);
    $display("Timeout after %0d cycles, the tests did not finish", (40 + num_ops) * 600);
    $display("RESULT: FAIL");
    $finish;
  end

  //////////////////////////////
  // Helpers
  function automatic cart_byte_t fill_byte(input int a);
    logic [15:0] w;
    w = 16'((a >> 1) * 16'h9e37) ^ 16'h5a3c; // Power-up word of the PSRAM model
    return a[0] ? w[7:0] : w[15:8];          // Odd byte on the low lane
  endfunction

  task automatic tick(input int n);
    repeat (n) @(posedge CLK2);
    #2;
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    errors++;
    $display("FAIL at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
  endtask

  task automatic wait_ready();
    int n;
    n = 0;
    while (!mcu_rdy && n < rdy_limit) begin
      tick(1);
      n++;
    end
    if (!mcu_rdy) begin
      errors++;
      $display("mcu_rdy stayed low for %0d cycles after a request", rdy_limit);
    end
  endtask

  task automatic send_request(input bit is_write, input rom_addr_t addr, input cart_byte_t data);
    mcu_addr  = addr;
    mcu_wdata = data;
    mcu_wrq   = is_write;
    mcu_rrq   = !is_write;
    tick(1);
    mcu_rrq = 1'b0;
    mcu_wrq = 1'b0;
    checks++;
    if (mcu_rdy !== 1'b0) report_mismatch("mcu_rdy", 0, mcu_rdy);
  endtask

  task automatic mcu_write(input rom_addr_t addr, input cart_byte_t data);
    send_request(1'b1, addr, data);
    wait_ready();
    ref_mem[addr] = data;
  endtask

  task automatic check_read_data(input rom_addr_t addr);
    checks++;
    if (mcu_rdata !== ref_mem[addr]) report_mismatch("mcu_rdata", ref_mem[addr], mcu_rdata);
  endtask

  task automatic mcu_read(input rom_addr_t addr);
    send_request(1'b0, addr, '0);
    wait_ready();
    check_read_data(addr);
  endtask

  //////////////////////////////
  // Test sequence
  initial begin : stimulus
    rom_addr_t  addr;
    cart_byte_t d0;
    void'($urandom(94));
    errors = 0;
    checks = 0;
    clk_mode = 0;
    rst_n = 1'b0;
    snes_addr = '0;
    snes_cpu_clk = 1'b0;
    snes_romsel_n = 1'b1;
    snes_read_n = 1'b1;
    snes_write_n = 1'b1;
    mcu_rrq = 1'b0;
    mcu_wrq = 1'b0;
    mcu_addr = '0;
    mcu_wdata = '0;
    for (int a = 0; a < mem_bytes; a++) ref_mem[a] = fill_byte(a);
    tick(16);
    rst_n = 1'b1;

    checks += 3;
    if (mcu_rdy !== 1'b1) report_mismatch("mcu_rdy", 1, mcu_rdy);
    if (rom_we_n !== 1'b1) report_mismatch("rom_we_n", 1, rom_we_n);
    if (rom_bhe_n !== ~rom_ble_n) report_mismatch("rom_bhe_n", !rom_ble_n, rom_bhe_n);

    tick(220); // Dead console, write then read back
    addr = rom_addr_t'($urandom_range(0, mem_bytes - 1));
    mcu_write(addr, cart_byte_t'($urandom));
    mcu_read(addr);

    // Neighbouring bytes of one word
    addr = rom_addr_t'($urandom_range(0, mem_bytes / 2 - 1) * 2);
    d0   = cart_byte_t'($urandom);
    mcu_write(addr, d0);
    mcu_write(addr + 1, ~d0);
    mcu_read(addr);
    mcu_read(addr + 1);

    // Console reads through the buffer
    for (int k = 0; k < 3; k++) begin
      snes_addr     = (k == 2) ? rom_addr_t'($urandom_range(0, mem_bytes - 1)) : addr + k;
      snes_romsel_n = 1'b0;
      snes_read_n   = 1'b0;
      tick(3);
      checks += 3;
      if (snes_rdata !== ref_mem[snes_addr]) begin
        report_mismatch("snes_rdata", ref_mem[snes_addr], snes_rdata);
      end
      if (snes_databus_dir !== 1'b1) report_mismatch("snes_databus_dir", 1, snes_databus_dir);
      if (snes_databus_oe_n !== 1'b0) report_mismatch("snes_databus_oe_n", 0, snes_databus_oe_n);
      snes_romsel_n = 1'b1;
      snes_read_n   = 1'b1;
      tick(2);
    end

    // Live console with no edges, no slot
    clk_mode = 1;
    tick(10);
    addr = rom_addr_t'($urandom_range(0, mem_bytes - 1));
    send_request(1'b0, addr, '0);
    for (int k = 0; k < 100; k++) begin
      tick(1);
      checks++;
      if (mcu_rdy !== 1'b0) report_mismatch("mcu_rdy", 0, mcu_rdy);
    end
    clk_mode = 0;
    wait_ready();
    check_read_data(addr);

    clk_mode = 2;
    for (int i = 0; i < num_ops; i++) begin
      addr = rom_addr_t'($urandom_range(0, mem_bytes - 1));
      if ($urandom_range(0, 1)) mcu_write(addr, cart_byte_t'($urandom));
      else mcu_read(addr);
      repeat ($urandom_range(0, 3)) tick(1);
    end
    clk_mode = 0;
    tick(5);

    $display("Checks %0d, errors %0d, assertion failures %0d", checks, errors,
             DUT.u_props.assert_fails);
    if (errors == 0 && DUT.u_props.assert_fails == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== bench/psram_model.sv ====
`default_nettype none

module psram_model #(
  parameter int word_addr_w = 10 // Words actually decoded
) (
  input  wire                           CLK2,
  input  wire cart_pkg::rom_word_addr_t addr,
  input  wire                           we_n,
  input  wire                           ble_n,
  input  wire                           bhe_n,
  input  wire cart_pkg::rom_word_t      wdata,
  output cart_pkg::rom_word_t           rdata
);

  import cart_pkg::*;

  rom_word_t              mem [0:(1 << word_addr_w)-1];
  logic [word_addr_w-1:0] idx;

  // Power-up contents, a hash of the word address
  initial begin
    for (int w = 0; w < (1 << word_addr_w); w++) mem[w] = 16'(w * 16'h9e37) ^ 16'h5a3c;
  end

  assign idx   = addr[word_addr_w-1:0];
  assign rdata = mem[idx]; // Asynchronous read

  always @(posedge CLK2) begin
    if (!we_n && !ble_n) mem[idx][7:0]  <= wdata[7:0];
    if (!we_n && !bhe_n) mem[idx][15:8] <= wdata[15:8];
  end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+logic
logic/cart_pkg.sv
logic/snes_bus_monitor.sv
logic/mcu_request_latch.sv
logic/rom_arbiter.sv
logic/cart_mem_top.sv
bench/psram_model.sv
bench/cart_mem_properties.sv
bench/cart_mem_tb.sv

// ==== logic/cart_macros.svh ====
`ifndef CART_MACROS_SVH
`define CART_MACROS_SVH

// Bus widths
`define CART_ROM_ADDR_W 24 // Byte address from console or MCU
`define CART_BYTE_W 8
`define CART_WORD_W 16     // PSRAM data bus

// Countdown reload, one MCU access lasts reload + 1 cycles
`define CART_ROM_CYCLE_LEN 7

// Console clock watchdog
`define CART_DEAD_TIMEOUT 88000 // About 1 ms of CLK2
`define CART_DEAD_CNT_W 18

`endif

// ==== logic/cart_mem_top.sv ====
`default_nettype none

`include "cart_macros.svh"

module cart_mem_top #(
  parameter int dead_timeout = `CART_DEAD_TIMEOUT
) (
  input  wire                       CLK2,
  input  wire                       rst_n,
  // Console bus
  input  wire cart_pkg::rom_addr_t  snes_addr,
  input  wire                       snes_cpu_clk,
  input  wire                       snes_romsel_n,
  input  wire                       snes_read_n,
  input  wire                       snes_write_n,
  output cart_pkg::cart_byte_t      snes_rdata,
  output logic                      snes_databus_oe_n,
  output logic                      snes_databus_dir,
  // MCU
  input  wire                       mcu_rrq,
  input  wire                       mcu_wrq,
  input  wire cart_pkg::rom_addr_t  mcu_addr,
  input  wire cart_pkg::cart_byte_t mcu_wdata,
  output cart_pkg::cart_byte_t      mcu_rdata,
  output logic                      mcu_rdy,
  // PSRAM
  output cart_pkg::rom_word_addr_t  rom_addr,
  output logic                      rom_we_n,
  output logic                      rom_ble_n,
  output logic                      rom_bhe_n,
  output cart_pkg::rom_word_t       rom_wdata,
  input  wire cart_pkg::rom_word_t  rom_rdata
);

  import cart_pkg::*;

  logic       free_slot;
  logic       snes_dead;
  logic       snes_wake;
  logic       rd_pend;
  logic       wr_pend;
  logic       access_done;
  rom_addr_t  req_addr;
  cart_byte_t req_wdata;

  snes_bus_monitor #(
    .dead_timeout(dead_timeout)
  ) u_bus_monitor (
    .CLK2              (CLK2),
    .rst_n             (rst_n),
    .snes_cpu_clk      (snes_cpu_clk),
    .snes_romsel_n     (snes_romsel_n),
    .snes_read_n       (snes_read_n),
    .snes_write_n      (snes_write_n),
    .free_slot         (free_slot),
    .snes_dead         (snes_dead),
    .snes_wake         (snes_wake),
    .snes_databus_oe_n (snes_databus_oe_n),
    .snes_databus_dir  (snes_databus_dir)
  );

  mcu_request_latch u_req_latch (
    .CLK2        (CLK2),
    .rst_n       (rst_n),
    .mcu_rrq     (mcu_rrq),
    .mcu_wrq     (mcu_wrq),
    .mcu_addr    (mcu_addr),
    .mcu_wdata   (mcu_wdata),
    .access_done (access_done),
    .rd_pend     (rd_pend),
    .wr_pend     (wr_pend),
    .req_addr    (req_addr),
    .req_wdata   (req_wdata),
    .mcu_rdy     (mcu_rdy)
  );

  rom_arbiter u_arbiter (
    .CLK2        (CLK2),
    .rst_n       (rst_n),
    .free_slot   (free_slot),
    .snes_dead   (snes_dead),
    .snes_wake   (snes_wake),
    .rd_pend     (rd_pend),
    .wr_pend     (wr_pend),
    .req_addr    (req_addr),
    .req_wdata   (req_wdata),
    .snes_addr   (snes_addr),
    .rom_rdata   (rom_rdata),
    .access_done (access_done),
    .rom_addr    (rom_addr),
    .rom_we_n    (rom_we_n),
    .rom_ble_n   (rom_ble_n),
    .rom_bhe_n   (rom_bhe_n),
    .rom_wdata   (rom_wdata),
    .mcu_rdata   (mcu_rdata),
    .snes_rdata  (snes_rdata)
  );

endmodule

`default_nettype wire

// ==== logic/cart_pkg.sv ====
`default_nettype none

`include "cart_macros.svh"

package cart_pkg;

  // Byte and word addresses
  typedef logic [`CART_ROM_ADDR_W-1:0] rom_addr_t;
  typedef logic [`CART_ROM_ADDR_W-2:0] rom_word_addr_t; // Byte address without bit 0

  // Data
  typedef logic [`CART_BYTE_W-1:0] cart_byte_t;
  typedef logic [`CART_WORD_W-1:0] rom_word_t;

  // Arbiter states, one-hot
  typedef enum logic [4:0] {
    IDLE        = 5'b00001,
    MCU_RD_ADDR = 5'b00010,
    MCU_RD_END  = 5'b00100,
    MCU_WR_ADDR = 5'b01000,
    MCU_WR_END  = 5'b10000
  } arb_state_t;

endpackage

`default_nettype wire

// ==== logic/mcu_request_latch.sv ====
`default_nettype none

module mcu_request_latch (
  input  wire                   CLK2,
  input  wire                   rst_n,
  input  wire                   mcu_rrq,
  input  wire                   mcu_wrq,
  input  wire cart_pkg::rom_addr_t  mcu_addr,
  input  wire cart_pkg::cart_byte_t mcu_wdata,
  input  wire                   access_done,
  output logic                  rd_pend,
  output logic                  wr_pend,
  output cart_pkg::rom_addr_t   req_addr,
  output cart_pkg::cart_byte_t  req_wdata,
  output logic                  mcu_rdy
);

  //////////////////////////////
  // Pending flags and ready
  always_ff @(posedge CLK2) begin
    if (!rst_n) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      mcu_rdy <= 1'b1;
    end else if (mcu_rrq) begin // Read wins over a write pulse
      rd_pend <= 1'b1;
      mcu_rdy <= 1'b0;
    end else if (mcu_wrq) begin
      wr_pend <= 1'b1;
      mcu_rdy <= 1'b0;
    end else if (access_done) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      mcu_rdy <= 1'b1;
    end
  end

  //////////////////////////////
  // Request payload
  always_ff @(posedge CLK2) begin
    if (mcu_rrq || mcu_wrq) begin
      req_addr <= mcu_addr;
    end
    // Write data kept apart so a read leaves it alone
    if (mcu_wrq && !mcu_rrq) begin
      req_wdata <= mcu_wdata;
    end
  end

endmodule

`default_nettype wire

// ==== logic/rom_arbiter.sv ====
`default_nettype none

`include "cart_macros.svh"

module rom_arbiter (
  input  wire                       CLK2,
  input  wire                       rst_n,
  input  wire                       free_slot,
  input  wire                       snes_dead,
  input  wire                       snes_wake,
  input  wire                       rd_pend,
  input  wire                       wr_pend,
  input  wire cart_pkg::rom_addr_t  req_addr,
  input  wire cart_pkg::cart_byte_t req_wdata,
  input  wire cart_pkg::rom_addr_t  snes_addr,
  input  wire cart_pkg::rom_word_t  rom_rdata,
  output logic                      access_done,
  output cart_pkg::rom_word_addr_t  rom_addr,
  output logic                      rom_we_n,
  output logic                      rom_ble_n,
  output logic                      rom_bhe_n,
  output cart_pkg::rom_word_t       rom_wdata,
  output cart_pkg::cart_byte_t      mcu_rdata,
  output cart_pkg::cart_byte_t      snes_rdata
);

  import cart_pkg::*;

  localparam int cnt_w = $clog2(`CART_ROM_CYCLE_LEN + 1);
  localparam logic [cnt_w-1:0] cycle_len = cnt_w'(`CART_ROM_CYCLE_LEN);

  arb_state_t       state;
  logic [cnt_w-1:0] delay_cnt; // Cycles left in the access state
  logic             mcu_hit;
  logic             addr0;     // Byte select of the active address
  cart_byte_t       rom_lane;

  //////////////////////////////
  // Slot FSM
  always_ff @(posedge CLK2) begin
    if (!rst_n) begin
      state     <= IDLE;
      delay_cnt <= '0;
    end else if (snes_wake) begin
      // Console came back, abort and retry later
      state <= IDLE;
    end else begin
      unique case (state)
        IDLE: begin
          if (free_slot || snes_dead) begin
            if (rd_pend) begin
              state     <= MCU_RD_ADDR;
              delay_cnt <= cycle_len;
            end else if (wr_pend) begin
              state     <= MCU_WR_ADDR;
              delay_cnt <= cycle_len;
            end
          end
        end
        MCU_RD_ADDR: begin
          delay_cnt <= delay_cnt - 1'b1;
          if (delay_cnt == '0) state <= MCU_RD_END;
        end
        MCU_WR_ADDR: begin
          delay_cnt <= delay_cnt - 1'b1;
          if (delay_cnt == '0) state <= MCU_WR_END;
        end
        MCU_RD_END, MCU_WR_END: begin
          state <= IDLE;
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  assign access_done = (state == MCU_RD_END) || (state == MCU_WR_END);

  assign mcu_hit = (state == MCU_RD_ADDR) || (state == MCU_WR_ADDR);

  //////////////////////////////
  // Memory address and lanes
  assign rom_addr = mcu_hit ? req_addr[`CART_ROM_ADDR_W-1:1]
                            : snes_addr[`CART_ROM_ADDR_W-1:1];
  assign addr0    = mcu_hit ? req_addr[0] : snes_addr[0];

  // Odd byte on the low lane
  assign rom_ble_n = ~addr0;
  assign rom_bhe_n = addr0;

  assign rom_we_n  = (state != MCU_WR_ADDR);
  assign rom_wdata = {req_wdata, req_wdata}; // Lane enable picks the byte

  //////////////////////////////
  // Read paths
  assign rom_lane = addr0 ? rom_rdata[`CART_BYTE_W-1:0]
                          : rom_rdata[`CART_WORD_W-1:`CART_BYTE_W];

  assign snes_rdata = rom_lane;

  // Last sample before the END state is the one kept
  always_ff @(posedge CLK2) begin
    if (state == MCU_RD_ADDR) begin
      mcu_rdata <= rom_lane;
    end
  end

endmodule

`default_nettype wire

// ==== logic/snes_bus_monitor.sv ====
`default_nettype none

`include "cart_macros.svh"

module snes_bus_monitor #(
  parameter int dead_timeout = `CART_DEAD_TIMEOUT
) (
  input  wire  CLK2,
  input  wire  rst_n,
  input  wire  snes_cpu_clk,
  input  wire  snes_romsel_n,
  input  wire  snes_read_n,
  input  wire  snes_write_n,
  output logic free_slot,
  output logic snes_dead,
  output logic snes_wake,
  output logic snes_databus_oe_n,
  output logic snes_databus_dir
);

  localparam logic [`CART_DEAD_CNT_W-1:0] dead_limit = `CART_DEAD_CNT_W'(dead_timeout);

  logic [4:0] cpu_clk_sr; // Bit 1 is the first usable sample
  logic [1:0] romsel_sr;
  logic [1:0] read_sr;
  logic [1:0] write_sr;
  logic       cycle_start;
  logic       cycle_end;
  logic       free_strobe;
  logic [`CART_DEAD_CNT_W-1:0] dead_cnt;

  //////////////////////////////
  // Strobe synchronizers
  always_ff @(posedge CLK2) begin
    if (!rst_n) begin
      cpu_clk_sr <= '0;
      romsel_sr  <= '1;
      read_sr    <= '1;
      write_sr   <= '1;
    end else begin
      cpu_clk_sr <= {cpu_clk_sr[3:0], snes_cpu_clk};
      romsel_sr  <= {romsel_sr[0], snes_romsel_n};
      read_sr    <= {read_sr[0], snes_read_n};
      write_sr   <= {write_sr[0], snes_write_n};
    end
  end

  // Edges need three stable samples before them
  assign cycle_start = (cpu_clk_sr[4:1] == 4'b0001);
  assign cycle_end   = (cpu_clk_sr[4:1] == 4'b1110);

  // A cycle off the ROM leaves the memory free
  always_ff @(posedge CLK2) begin
    if (!rst_n) free_strobe <= 1'b0;
    else        free_strobe <= cycle_start & romsel_sr[1];
  end

  assign free_slot = cycle_end | free_strobe;

  //////////////////////////////
  // Dead console watchdog
  always_ff @(posedge CLK2) begin
    if (!rst_n) begin
      dead_cnt  <= '0;
      snes_dead <= 1'b1; // Assume no console until its clock runs
    end else begin
      if (cpu_clk_sr[1])       dead_cnt <= '0;
      else if (dead_cnt != '1) dead_cnt <= dead_cnt + 1'b1; // Saturates
      if (cpu_clk_sr[1])              snes_dead <= 1'b0;
      else if (dead_cnt > dead_limit) snes_dead <= 1'b1;
    end
  end

  assign snes_wake = snes_dead & cpu_clk_sr[1];

  // Data buffer
  assign snes_databus_oe_n = romsel_sr[1] | (read_sr[1] & write_sr[1]);
  assign snes_databus_dir  = ~read_sr[1]; // 1 drives toward the console

endmodule

`default_nettype wire
